//--- Bender.yml
package:
  name: conv_engine

sources:
  - common/conv_pkg.sv
  - hdl/column_memory.sv
  - hdl/wb_host_regs.sv
  - hdl/strip_sequencer.sv
  - conv_array/conv_unit.sv
  - hdl/result_collector.sv
  - hdl/conv_engine_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_conv_engine.sv

//--- common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int WB_DATA_W = 32;

    typedef logic [7:0] pixel_t;
    typedef logic signed [7:0] coef_t;

    // row-major, element r*3+c
    typedef coef_t [8:0] kernel_t;

    // full nine-product sum, also the stored result word
    typedef logic signed [19:0] acc_t;

    // upper address bits select the region
    typedef logic [3:0] region_t;

    localparam region_t REGION_REGS        = 4'd0;
    localparam region_t REGION_PIX_BASE    = 4'd1;
    localparam region_t REGION_RESULT_BASE = 4'd8;

    localparam int REG_IDX_W = 3;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam reg_idx_t REG_CTRL        = 3'd0;
    localparam reg_idx_t REG_STATUS      = 3'd1;
    localparam reg_idx_t REG_HEIGHT      = 3'd2;
    localparam reg_idx_t REG_KERNEL_ROW0 = 3'd3;
    localparam reg_idx_t REG_KERNEL_ROW1 = 3'd4;
    localparam reg_idx_t REG_KERNEL_ROW2 = 3'd5;

endpackage

`default_nettype wire

//--- conv_array/conv_unit.sv
`timescale 1ns/10ps
`default_nettype none

module conv_unit (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_sof,
    input  wire logic                   i_valid,
    input  wire conv_pkg::pixel_t [2:0] i_pix,
    input  wire conv_pkg::kernel_t      i_kernel,
    output logic                        o_valid,
    output conv_pkg::acc_t              o_result
);

    // 9x8 signed product, fits 17 bits
    typedef logic signed [16:0] prod_t;

    conv_pkg::pixel_t [2:0] row_old;
    conv_pkg::pixel_t [2:0] row_mid;
    conv_pkg::pixel_t [2:0] win [3];
    logic [1:0]             row_cnt;
    logic                   win_full;
    prod_t                  prod [9];
    logic                   prod_valid;
    conv_pkg::acc_t         sum;

    // window as seen with the incoming row at the bottom
    assign win[0] = row_old;
    assign win[1] = row_mid;
    assign win[2] = i_pix;

    assign win_full = i_valid && !i_sof && row_cnt >= 2'd2;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            row_cnt    <= '0;
            prod_valid <= 1'b0;
            o_valid    <= 1'b0;
        end else begin
            prod_valid <= win_full;
            o_valid    <= prod_valid;
            if (i_valid) begin
                if (i_sof) begin
                    row_cnt <= 2'd1;
                end else if (row_cnt != 2'd3) begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    // stage one, nine products
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            row_old <= row_mid;
            row_mid <= i_pix;
        end
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                prod[r*3+c] <= $signed({1'b0, win[r][c]}) * i_kernel[r*3+c];
            end
        end
    end

    always_comb begin
        sum = '0;
        for (int i = 0; i < 9; i++) begin
            sum = sum + conv_pkg::acc_t'(prod[i]);
        end
    end

    // stage two, the sum
    always_ff @(posedge i_clk) begin
        o_result <= sum;
    end

    a_sof_with_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sof |-> i_valid);

endmodule

`default_nettype wire

//--- hdl/column_memory.sv
`timescale 1ns/10ps
`default_nettype none

module column_memory #(
    parameter type t_word     = logic [7:0],
    parameter int  ROW_ADDR_W = 6
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_we,
    input  wire logic [ROW_ADDR_W-1:0] i_waddr,
    input  wire t_word                 i_wdata,
    input  wire logic [ROW_ADDR_W-1:0] i_raddr,
    output t_word                      o_rdata
);

    t_word mem [2**ROW_ADDR_W];

    // one write port, registered read
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

//--- hdl/conv_engine_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_engine_top #(
    parameter int N_CONV     = 4,
    parameter int ROW_ADDR_W = 6
) (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst_n,
    input  wire logic                             i_wb_cyc,
    input  wire logic                             i_wb_stb,
    input  wire logic                             i_wb_we,
    input  wire logic [ROW_ADDR_W+3:0]            i_wb_adr,
    input  wire logic [conv_pkg::WB_DATA_W-1:0]   i_wb_dat,
    input  wire logic [conv_pkg::WB_DATA_W/8-1:0] i_wb_sel,
    output logic [conv_pkg::WB_DATA_W-1:0]        o_wb_dat,
    output logic                                  o_wb_ack
);

    logic                          start;
    logic                          busy;
    logic                          done;
    logic [ROW_ADDR_W:0]           height;
    conv_pkg::kernel_t             kernel;
    logic [N_CONV+1:0]             pix_we;
    logic [ROW_ADDR_W-1:0]         pix_waddr;
    conv_pkg::pixel_t              pix_wdata;
    logic [ROW_ADDR_W-1:0]         pix_raddr;
    conv_pkg::pixel_t [N_CONV+1:0] pix_rdata;
    logic                          pix_valid;
    logic                          sof;
    logic [N_CONV-1:0]             conv_valid;
    conv_pkg::acc_t [N_CONV-1:0]   conv_result;
    logic                          res_we;
    logic [ROW_ADDR_W-1:0]         res_waddr;
    conv_pkg::acc_t [N_CONV-1:0]   res_wdata;
    logic [ROW_ADDR_W-1:0]         res_raddr;
    conv_pkg::acc_t [N_CONV-1:0]   res_rdata;

    wb_host_regs #(
        .N_CONV     (N_CONV),
        .ROW_ADDR_W (ROW_ADDR_W)
    ) u_host (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .i_wb_sel    (i_wb_sel),
        .i_busy      (busy),
        .i_done      (done),
        .i_res_rdata (res_rdata),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_start     (start),
        .o_height    (height),
        .o_kernel    (kernel),
        .o_pix_we    (pix_we),
        .o_pix_waddr (pix_waddr),
        .o_pix_wdata (pix_wdata),
        .o_res_raddr (res_raddr)
    );

    strip_sequencer #(
        .ROW_ADDR_W (ROW_ADDR_W)
    ) u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (start),
        .i_height    (height),
        .o_raddr     (pix_raddr),
        .o_pix_valid (pix_valid),
        .o_sof       (sof)
    );

    for (genvar k = 0; k < N_CONV + 2; k++) begin : gen_pix_mem
        column_memory #(
            .t_word     (conv_pkg::pixel_t),
            .ROW_ADDR_W (ROW_ADDR_W)
        ) u_mem (
            .i_clk   (i_clk),
            .i_we    (pix_we[k]),
            .i_waddr (pix_waddr),
            .i_wdata (pix_wdata),
            .i_raddr (pix_raddr),
            .o_rdata (pix_rdata[k])
        );
    end

    // unit k sees pixel columns k, k+1 and k+2
    for (genvar k = 0; k < N_CONV; k++) begin : gen_conv
        conv_unit u_conv (
            .i_clk    (i_clk),
            .i_rst_n  (i_rst_n),
            .i_sof    (sof),
            .i_valid  (pix_valid),
            .i_pix    (pix_rdata[k+2:k]),
            .i_kernel (kernel),
            .o_valid  (conv_valid[k]),
            .o_result (conv_result[k])
        );
    end

    // units run in lockstep, unit 0 stands for all
    result_collector #(
        .N_CONV     (N_CONV),
        .ROW_ADDR_W (ROW_ADDR_W)
    ) u_collect (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (start),
        .i_height  (height),
        .i_valid   (conv_valid[0]),
        .i_results (conv_result),
        .o_we      (res_we),
        .o_waddr   (res_waddr),
        .o_wdata   (res_wdata),
        .o_busy    (busy),
        .o_done    (done)
    );

    for (genvar k = 0; k < N_CONV; k++) begin : gen_res_mem
        column_memory #(
            .t_word     (conv_pkg::acc_t),
            .ROW_ADDR_W (ROW_ADDR_W)
        ) u_mem (
            .i_clk   (i_clk),
            .i_we    (res_we),
            .i_waddr (res_waddr),
            .i_wdata (res_wdata[k]),
            .i_raddr (res_raddr),
            .o_rdata (res_rdata[k])
        );
    end

endmodule

`default_nettype wire

//--- hdl/result_collector.sv
`timescale 1ns/10ps
`default_nettype none

module result_collector #(
    parameter int N_CONV     = 4,
    parameter int ROW_ADDR_W = 6
) (
    input  wire logic                        i_clk,
    input  wire logic                        i_rst_n,
    input  wire logic                        i_start,
    input  wire logic [ROW_ADDR_W:0]         i_height,
    input  wire logic                        i_valid,
    input  wire conv_pkg::acc_t [N_CONV-1:0] i_results,
    output logic                             o_we,
    output logic [ROW_ADDR_W-1:0]            o_waddr,
    output conv_pkg::acc_t [N_CONV-1:0]      o_wdata,
    output logic                             o_busy,
    output logic                             o_done
);

    localparam int H_W = ROW_ADDR_W + 1;

    logic [H_W-1:0] cnt;
    logic           short_run;

    // fewer than three rows gives no output row at all
    assign short_run = i_height < H_W'(3);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt     <= '0;
            o_we    <= 1'b0;
            o_waddr <= '0;
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_we <= i_valid;
            if (i_valid) begin
                o_waddr <= cnt[ROW_ADDR_W-1:0];
            end
            if (i_start) begin
                cnt    <= '0;
                o_busy <= 1'b1;
                o_done <= 1'b0;
            end else if (o_busy) begin
                if (short_run) begin
                    // counts read cycles instead of results
                    if (cnt == i_height) begin
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end else begin
                    if (i_valid) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (o_we && cnt == i_height - H_W'(2)) begin
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_wdata <= i_results;
        end
    end

    a_valid_only_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> o_busy);

endmodule

`default_nettype wire

//--- hdl/strip_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module strip_sequencer #(
    parameter int ROW_ADDR_W = 6
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_start,
    input  wire logic [ROW_ADDR_W:0]   i_height,
    output logic [ROW_ADDR_W-1:0]      o_raddr,
    output logic                       o_pix_valid,
    output logic                       o_sof
);

    typedef enum logic {
        ST_IDLE,
        ST_READ
    } state_t;

    state_t state;
    logic   last_row;

    assign last_row = {1'b0, o_raddr} == i_height - 1'b1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            o_raddr     <= '0;
            o_pix_valid <= 1'b0;
            o_sof       <= 1'b0;
        end else begin
            // one cycle behind the address, matching the memory read
            o_pix_valid <= state == ST_READ;
            o_sof       <= state == ST_READ && o_raddr == '0;
            case (state)
                ST_IDLE: begin
                    if (i_start && i_height != '0) begin
                        state   <= ST_READ;
                        o_raddr <= '0;
                    end
                end
                ST_READ: begin
                    if (last_row) begin
                        state <= ST_IDLE;
                    end else begin
                        o_raddr <= o_raddr + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_raddr_in_image: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state == ST_READ |-> {1'b0, o_raddr} < i_height);

endmodule

`default_nettype wire

//--- hdl/wb_host_regs.sv
`timescale 1ns/10ps
`default_nettype none

module wb_host_regs #(
    parameter int N_CONV     = 4,
    parameter int ROW_ADDR_W = 6
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_wb_cyc,
    input  wire logic                          i_wb_stb,
    input  wire logic                          i_wb_we,
    input  wire logic [ROW_ADDR_W+3:0]         i_wb_adr,
    input  wire logic [conv_pkg::WB_DATA_W-1:0] i_wb_dat,
    input  wire logic [conv_pkg::WB_DATA_W/8-1:0] i_wb_sel,
    input  wire logic                          i_busy,
    input  wire logic                          i_done,
    input  wire conv_pkg::acc_t [N_CONV-1:0]   i_res_rdata,
    output logic [conv_pkg::WB_DATA_W-1:0]     o_wb_dat,
    output logic                               o_wb_ack,
    output logic                               o_start,
    output logic [ROW_ADDR_W:0]                o_height,
    output conv_pkg::kernel_t                  o_kernel,
    output logic [N_CONV+1:0]                  o_pix_we,
    output logic [ROW_ADDR_W-1:0]              o_pix_waddr,
    output conv_pkg::pixel_t                   o_pix_wdata,
    output logic [ROW_ADDR_W-1:0]              o_res_raddr
);

    localparam int DW = conv_pkg::WB_DATA_W;

    conv_pkg::region_t     region;
    conv_pkg::region_t     rd_region;
    logic [ROW_ADDR_W-1:0] row;
    logic [ROW_ADDR_W+3:0] adr_q;
    logic                  req;
    logic                  wr;

    // register window is the first few rows of region 0
    function automatic logic is_reg(input logic [ROW_ADDR_W+3:0] adr);
        return adr[ROW_ADDR_W+3:ROW_ADDR_W] == conv_pkg::REGION_REGS &&
               (adr[ROW_ADDR_W-1:0] >> conv_pkg::REG_IDX_W) == '0;
    endfunction

    assign region    = i_wb_adr[ROW_ADDR_W+3:ROW_ADDR_W];
    assign row       = i_wb_adr[ROW_ADDR_W-1:0];
    assign rd_region = adr_q[ROW_ADDR_W+3:ROW_ADDR_W];
    assign req       = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign wr        = req && i_wb_we;

    assign o_pix_waddr = row;
    assign o_pix_wdata = i_wb_dat[7:0];
    // result memories read in the request cycle, data lands with ack
    assign o_res_raddr = row;

    always_comb begin
        for (int k = 0; k < N_CONV + 2; k++) begin
            o_pix_we[k] = wr && region == conv_pkg::region_t'(conv_pkg::REGION_PIX_BASE + k);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
            o_start  <= 1'b0;
            o_height <= '0;
            o_kernel <= '0;
        end else begin
            o_wb_ack <= req;
            o_start  <= 1'b0;
            if (wr && is_reg(i_wb_adr)) begin
                case (i_wb_adr[conv_pkg::REG_IDX_W-1:0])
                    conv_pkg::REG_CTRL:        o_start <= i_wb_dat[0] && !i_busy;
                    conv_pkg::REG_HEIGHT:      o_height <= i_wb_dat[ROW_ADDR_W:0];
                    conv_pkg::REG_KERNEL_ROW0: o_kernel[2:0] <= i_wb_dat[23:0];
                    conv_pkg::REG_KERNEL_ROW1: o_kernel[5:3] <= i_wb_dat[23:0];
                    conv_pkg::REG_KERNEL_ROW2: o_kernel[8:6] <= i_wb_dat[23:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        adr_q <= i_wb_adr;
    end

    // read mux, decoded from the address held since the request cycle
    always_comb begin
        o_wb_dat = '0;
        if (is_reg(adr_q)) begin
            case (adr_q[conv_pkg::REG_IDX_W-1:0])
                conv_pkg::REG_STATUS:      o_wb_dat[1:0] = {i_done, i_busy};
                conv_pkg::REG_HEIGHT:      o_wb_dat[ROW_ADDR_W:0] = o_height;
                conv_pkg::REG_KERNEL_ROW0: o_wb_dat[23:0] = o_kernel[2:0];
                conv_pkg::REG_KERNEL_ROW1: o_wb_dat[23:0] = o_kernel[5:3];
                conv_pkg::REG_KERNEL_ROW2: o_wb_dat[23:0] = o_kernel[8:6];
                default: ;
            endcase
        end
        for (int k = 0; k < N_CONV; k++) begin
            if (rd_region == conv_pkg::region_t'(conv_pkg::REGION_RESULT_BASE + k)) begin
                // signed source, so this sign-extends
                o_wb_dat = DW'(i_res_rdata[k]);
            end
        end
    end

    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> i_wb_cyc && i_wb_stb);

    a_full_word_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_cyc && i_wb_stb && i_wb_we |-> &i_wb_sel);

endmodule

`default_nettype wire

//--- sim.f
common/conv_pkg.sv
hdl/column_memory.sv
hdl/wb_host_regs.sv
hdl/strip_sequencer.sv
conv_array/conv_unit.sv
hdl/result_collector.sv
hdl/conv_engine_top.sv
sim/tb_clock_gen.sv
sim/tb_conv_engine.sv

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_conv_engine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_conv_engine;

    localparam int N_CONV     = 4;
    localparam int ROW_ADDR_W = 6;
    localparam int ADR_W      = ROW_ADDR_W + 4;
    localparam int DW         = conv_pkg::WB_DATA_W;
    localparam int N_COLS     = N_CONV + 2;
    localparam int MAX_ROWS   = 2 ** ROW_ADDR_W;
    // each image row loaded over all tests costs a few dozen cycles
    localparam int TOTAL_ROWS      = 8 + MAX_ROWS + 8 + 3 + 8;
    localparam int WATCHDOG_CYCLES = 1000 + 200 * TOTAL_ROWS;
    localparam int ACK_LIMIT       = 16;
    localparam int POLL_LIMIT      = 200;

    logic             clk;
    logic             rst_n;
    logic             wb_cyc   = 1'b0;
    logic             wb_stb   = 1'b0;
    logic             wb_we    = 1'b0;
    logic [ADR_W-1:0] wb_adr   = '0;
    logic [DW-1:0]    wb_dat_w = '0;
    logic [DW/8-1:0]  wb_sel   = '1;
    logic [DW-1:0]    wb_dat_r;
    logic             wb_ack;

    integer           seed = 32'h0abc_d03d;
    int               errors = 0;
    int               tests_passed = 0;
    int               tests_failed = 0;
    conv_pkg::pixel_t pix_img [N_COLS][MAX_ROWS];
    conv_pkg::coef_t  kern [9];

    tb_clock_gen #(.RESET_CYCLES(5)) u_clk (.o_clk(clk), .o_rst_n(rst_n));

    conv_engine_top #(
        .N_CONV     (N_CONV),
        .ROW_ADDR_W (ROW_ADDR_W)
    ) i_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat_w),
        .i_wb_sel (wb_sel),
        .o_wb_dat (wb_dat_r),
        .o_wb_ack (wb_ack)
    );

    function automatic logic [ADR_W-1:0] make_adr(input conv_pkg::region_t region, input int row);
        return {region, ROW_ADDR_W'(row)};
    endfunction

    function automatic logic [ADR_W-1:0] reg_adr(input conv_pkg::reg_idx_t idx);
        return make_adr(conv_pkg::REGION_REGS, int'(idx));
    endfunction

    function automatic logic [ADR_W-1:0] res_adr(input int k, input int row);
        return make_adr(conv_pkg::region_t'(conv_pkg::REGION_RESULT_BASE + k), row);
    endfunction

    // top kernel row multiplies the oldest image row
    function automatic int expected_sum(input int k, input int r);
        int sum;
        int c;
        int p;
        sum = 0;
        for (int kr = 0; kr < 3; kr++) begin
            for (int kc = 0; kc < 3; kc++) begin
                c = kern[kr*3+kc];
                p = pix_img[k+kc][r+kr];
                sum = sum + c * p;
            end
        end
        return sum;
    endfunction

    task automatic check_acc(input string name, input conv_pkg::acc_t got,
                             input conv_pkg::acc_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ack(input logic [ADR_W-1:0] adr);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (wb_ack !== 1'b1 && n < ACK_LIMIT);
        if (wb_ack !== 1'b1) begin
            $display("no acknowledge for bus access to address %h at %0t", adr, $time);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DW-1:0] dat);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        wait_ack(adr);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DW-1:0] dat);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        wait_ack(adr);
        dat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic write_kernel();
        for (int r = 0; r < 3; r++) begin
            wb_write(reg_adr(conv_pkg::reg_idx_t'(int'(conv_pkg::REG_KERNEL_ROW0) + r)),
                     {8'h00, kern[r*3+2], kern[r*3+1], kern[r*3]});
        end
    endtask

    task automatic fill_random_pixels(input int height);
        for (int c = 0; c < N_COLS; c++) begin
            for (int r = 0; r < height; r++) begin
                pix_img[c][r] = conv_pkg::pixel_t'($random(seed));
            end
        end
    endtask

    task automatic write_pixels(input int height);
        for (int c = 0; c < N_COLS; c++) begin
            for (int r = 0; r < height; r++) begin
                wb_write(make_adr(conv_pkg::region_t'(conv_pkg::REGION_PIX_BASE + c), r),
                         DW'(pix_img[c][r]));
            end
        end
    endtask

    task automatic start_run(input int height);
        wb_write(reg_adr(conv_pkg::REG_HEIGHT), DW'(height));
        wb_write(reg_adr(conv_pkg::REG_CTRL), 32'h1);
    endtask

    task automatic wait_done(input string what);
        logic [DW-1:0] st;
        int            polls;
        st    = '0;
        polls = 0;
        while (st[1] !== 1'b1 && polls < POLL_LIMIT) begin
            wb_read(reg_adr(conv_pkg::REG_STATUS), st);
            polls++;
        end
        if (st[1] !== 1'b1) begin
            $display("%s: engine never reported done", what);
            errors++;
        end else begin
            check_word("status", st, 32'h2);
        end
    endtask

    // result words must come back sign-extended to the bus width
    task automatic read_result(input int k, input int r, input conv_pkg::acc_t exp);
        logic [DW-1:0] word;
        wb_read(res_adr(k, r), word);
        check_acc($sformatf("res%0d[%0d]", k, r), conv_pkg::acc_t'(word[19:0]), exp);
        check_word($sformatf("res%0d[%0d] bus word", k, r), word, DW'(exp));
    endtask

    task automatic check_run(input int height);
        for (int k = 0; k < N_CONV; k++) begin
            for (int r = 0; r < height - 2; r++) begin
                read_result(k, r, conv_pkg::acc_t'(expected_sum(k, r)));
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    task automatic test_register_readback();
        int            err0;
        logic [DW-1:0] rd;
        err0 = errors;
        wb_read(reg_adr(conv_pkg::REG_STATUS), rd);
        check_word("status", rd, '0);
        for (int i = 0; i < 9; i++) begin
            kern[i] = conv_pkg::coef_t'($random(seed));
        end
        write_kernel();
        wb_write(reg_adr(conv_pkg::REG_HEIGHT), 32'd37);
        for (int r = 0; r < 3; r++) begin
            wb_read(reg_adr(conv_pkg::reg_idx_t'(int'(conv_pkg::REG_KERNEL_ROW0) + r)), rd);
            check_word($sformatf("kernel row %0d", r), rd,
                       {8'h00, kern[r*3+2], kern[r*3+1], kern[r*3]});
        end
        wb_read(reg_adr(conv_pkg::REG_HEIGHT), rd);
        check_word("height", rd, 32'd37);
        wb_read(make_adr(conv_pkg::region_t'(4'hf), 0), rd);
        check_word("unmapped region", rd, '0);
        wb_read(make_adr(conv_pkg::REGION_REGS, 7), rd);
        check_word("unmapped register", rd, '0);
        end_test("register readback", err0);
    endtask

    task automatic test_identity_kernel();
        int err0;
        err0 = errors;
        for (int i = 0; i < 9; i++) begin
            kern[i] = (i == 4) ? 8'sd1 : 8'sd0;
        end
        write_kernel();
        fill_random_pixels(8);
        write_pixels(8);
        start_run(8);
        wait_done("identity kernel");
        // centre tap picks the pixel one row down and one column right
        for (int k = 0; k < N_CONV; k++) begin
            for (int r = 0; r < 6; r++) begin
                read_result(k, r, conv_pkg::acc_t'(pix_img[k+1][r+1]));
            end
        end
        end_test("identity kernel", err0);
    endtask

    task automatic test_mixed_kernel();
        int err0;
        err0 = errors;
        for (int i = 0; i < 9; i++) begin
            kern[i] = conv_pkg::coef_t'($random(seed));
        end
        // force one tap of each sign
        if (kern[4] >= 0) begin
            kern[4] = ~kern[4];
        end
        if (kern[0] < 0) begin
            kern[0] = ~kern[0];
        end
        write_kernel();
        fill_random_pixels(MAX_ROWS);
        write_pixels(MAX_ROWS);
        start_run(MAX_ROWS);
        wait_done("mixed kernel");
        check_run(MAX_ROWS);
        end_test("mixed-sign kernel", err0);
    endtask

    task automatic test_extreme_values();
        int err0;
        err0 = errors;
        for (int i = 0; i < 9; i++) begin
            kern[i] = -8'sd128;
        end
        for (int c = 0; c < N_COLS; c++) begin
            for (int r = 0; r < 8; r++) begin
                pix_img[c][r] = 8'd255;
            end
        end
        write_kernel();
        write_pixels(8);
        start_run(8);
        wait_done("extreme values");
        for (int k = 0; k < N_CONV; k++) begin
            for (int r = 0; r < 6; r++) begin
                read_result(k, r, conv_pkg::acc_t'(-293760));
            end
        end
        end_test("extreme values", err0);
    endtask

    task automatic test_short_and_restart();
        int            err0;
        logic [DW-1:0] rd;
        err0 = errors;
        for (int i = 0; i < 9; i++) begin
            kern[i] = conv_pkg::coef_t'($random(seed));
        end
        write_kernel();
        fill_random_pixels(3);
        write_pixels(3);
        start_run(3);
        wait_done("height 3 run");
        for (int k = 0; k < N_CONV; k++) begin
            read_result(k, 0, conv_pkg::acc_t'(expected_sum(k, 0)));
            // row 1 still holds the previous run
            read_result(k, 1, conv_pkg::acc_t'(-293760));
        end
        fill_random_pixels(8);
        write_pixels(8);
        start_run(8);
        wb_read(reg_adr(conv_pkg::REG_STATUS), rd);
        check_word("status", rd, 32'h1);
        // second start lands mid-run
        wb_write(reg_adr(conv_pkg::REG_CTRL), 32'h1);
        wait_done("restart run");
        check_run(8);
        end_test("short image and restart", err0);
    endtask

    initial begin
        @(posedge rst_n);
        @(posedge clk);
        test_register_readback();
        test_identity_kernel();
        test_mixed_kernel();
        test_extreme_values();
        test_short_and_restart();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
